// File: Bender.yml
package:
  name: load_requester

sources:
  - verilog/lrq_cfg_pkg.sv
  - verilog/lrq_types_pkg.sv
  - verilog/lrq_entry.sv
  - verilog/lrq_alloc.sv
  - verilog/lrq_issue.sv
  - verilog/lrq_refill.sv
  - verilog/load_requester.sv
  - target: simulation
    files:
      - sim/lrq_checker.sv
      - sim/tb_load_requester.sv

// File: sim/lrq_checker.sv
`default_nettype none

module lrq_checker (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  input  lrq_types_pkg::port_mask_t  i_load,
  input  lrq_types_pkg::paddr_t      i_load_paddr        [lrq_cfg_pkg::LOAD_PORTS],
  input  lrq_types_pkg::port_mask_t  i_conflict,
  input  lrq_types_pkg::entry_mask_t i_conflict_index_oh [lrq_cfg_pkg::LOAD_PORTS],
  input  lrq_types_pkg::port_mask_t  i_full,
  input  logic                       i_req_valid,
  input  logic                       i_req_ready,
  input  lrq_types_pkg::l2_cmd_t     i_req_cmd,
  input  lrq_types_pkg::paddr_t      i_req_addr,
  input  lrq_types_pkg::l2_tag_t     i_req_tag,
  input  logic                       i_resp_valid,
  input  lrq_types_pkg::l2_tag_t     i_resp_tag,
  input  lrq_types_pkg::line_data_t  i_resp_data,
  input  logic                       i_l1d_wr_valid,
  input  lrq_types_pkg::paddr_t      i_l1d_wr_paddr,
  input  lrq_types_pkg::byte_en_t    i_l1d_wr_be,
  input  lrq_types_pkg::line_data_t  i_l1d_wr_data,
  input  logic                       i_resolve_valid,
  input  lrq_types_pkg::entry_mask_t i_resolve_index_oh,
  output int                         o_errors,
  output int                         o_checks,
  output logic                       o_idle
);

  timeunit 1ns;
  timeprecision 1ps;

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  // Response pipe with the L1D write at stage 2 and the resolve at stage 3
  localparam int PIPE = 4;

  entry_state_t m_state [ENTRIES];
  line_addr_t   m_line  [ENTRIES];
  int           in_idx;
  int           out_idx;
  logic         pv      [PIPE];
  int           pidx    [PIPE];
  line_data_t   pdata   [PIPE];

  initial begin
    o_errors = 0;
    o_checks = 0;
  end

  task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
    o_checks = o_checks + 1;
    if (got !== exp) begin
      o_errors = o_errors + 1;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  always_comb begin
    o_idle = 1'b1;
    for (int e = 0; e < ENTRIES; e++) begin
      if (m_state[e] != ST_EMPTY) begin
        o_idle = 1'b0;
      end
    end
    for (int k = 0; k < PIPE; k++) begin
      if (pv[k]) begin
        o_idle = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Model step once per cycle while inputs are stable
  // ----------------------------------------------------------------------
  always @(negedge i_clk) begin : step
    line_addr_t  ln [LOAD_PORTS];
    entry_mask_t idx_oh;
    logic        conf;
    logic        found;
    int          free;
    int          rank;
    int          pick;
    int          pos;
    int          acc_n;
    int          acc_e [LOAD_PORTS];
    line_addr_t  acc_l [LOAD_PORTS];

    if (!i_reset_n) begin
      for (int e = 0; e < ENTRIES; e++) begin
        m_state[e] = ST_EMPTY;
        m_line[e]  = '0;
      end
      for (int k = 0; k < PIPE; k++) begin
        pv[k] = 1'b0;
      end
      in_idx  = 0;
      out_idx = 0;
    end else begin
      for (int k = PIPE - 1; k > 0; k--) begin
        pv[k]    = pv[k-1];
        pidx[k]  = pidx[k-1];
        pdata[k] = pdata[k-1];
      end
      pv[0]    = i_resp_valid && (i_resp_tag[TAG_W-1:ENTRY_W] == TAG_SRC_RD_L1D);
      pidx[0]  = int'(i_resp_tag[ENTRY_W-1:0]);
      pdata[0] = i_resp_data;

      free = 0;
      for (int e = 0; e < ENTRIES; e++) begin
        if (m_state[e] == ST_EMPTY) begin
          free++;
        end
      end

      // Load flags and allocation
      rank  = 0;
      acc_n = 0;
      for (int p = 0; p < LOAD_PORTS; p++) begin
        ln[p]  = i_load_paddr[p][PADDR_W-1:LINE_OFFSET_W];
        idx_oh = '0;
        for (int e = 0; e < ENTRIES; e++) begin
          idx_oh[e] = i_load[p] && (m_state[e] != ST_EMPTY) && (m_line[e] == ln[p]);
        end
        conf = |idx_oh;
        for (int q = 0; q < p; q++) begin
          if (i_load[q] && i_load[p] && (ln[q] == ln[p])) begin
            conf = 1'b1;
          end
        end
        check_eq($sformatf("conflict[%0d]", p), i_conflict[p], conf);
        check_eq($sformatf("conflict index[%0d]", p), i_conflict_index_oh[p], idx_oh);
        check_eq($sformatf("full[%0d]", p), i_full[p], i_load[p] && !conf && (rank >= free));
        if (i_load[p] && !conf) begin
          if (rank < free) begin
            acc_e[acc_n] = (in_idx + rank) % ENTRIES;
            acc_l[acc_n] = ln[p];
            acc_n++;
          end
          rank++;
        end
      end

      // Oldest unsent entry from the out-pointer
      found = 1'b0;
      pick  = 0;
      for (int k = 0; k < ENTRIES; k++) begin
        pos = (out_idx + k) % ENTRIES;
        if (!found && (m_state[pos] == ST_WAIT_SEND)) begin
          found = 1'b1;
          pick  = pos;
        end
      end
      check_eq("req valid", i_req_valid, found);
      if (found) begin
        check_eq("req cmd", i_req_cmd, CMD_RD_LINE);
        check_eq("req addr", i_req_addr, {m_line[pick], {LINE_OFFSET_W{1'b0}}});
        check_eq("req tag", i_req_tag, {TAG_SRC_RD_L1D, entry_idx_t'(pick)});
      end

      check_eq("l1d write valid", i_l1d_wr_valid, pv[2]);
      if (pv[2]) begin
        check_eq("l1d write addr", i_l1d_wr_paddr, {m_line[pidx[2]], {LINE_OFFSET_W{1'b0}}});
        check_eq("l1d write be", i_l1d_wr_be, {LINE_BYTES{1'b1}});
        check_eq("l1d write data", i_l1d_wr_data, pdata[2]);
      end
      check_eq("resolve valid", i_resolve_valid, pv[3]);
      if (pv[3]) begin
        check_eq("resolve index", i_resolve_index_oh, entry_mask_t'(1) << pidx[3]);
      end

      // State updates for the coming edge
      if (m_state[out_idx] == ST_RESOLVED) begin
        m_state[out_idx] = ST_EMPTY;
        out_idx = (out_idx + 1) % ENTRIES;
      end
      if (pv[2]) begin
        if (m_state[pidx[2]] == ST_WAIT_RESP) begin
          m_state[pidx[2]] = ST_RESOLVED;
        end else begin
          o_errors = o_errors + 1;
          $display("Response at %0t named entry %0d, which had no read outstanding",
                   $time, pidx[2]);
        end
      end
      if (found && i_req_ready) begin
        m_state[pick] = ST_WAIT_RESP;
      end
      for (int a = 0; a < acc_n; a++) begin
        m_state[acc_e[a]] = ST_WAIT_SEND;
        m_line[acc_e[a]]  = acc_l[a];
      end
      in_idx = (in_idx + acc_n) % ENTRIES;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_load_requester.sv
`default_nettype none

module tb_load_requester;

  timeunit 1ns;
  timeprecision 1ps;

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  localparam int ROWS         = 18;
  localparam int MAX_DELAY    = 5;
  localparam int FOREIGN_CYC  = 12;
  localparam int SEED         = 84;

  logic        i_clk;
  logic        i_reset_n;
  port_mask_t  i_load;
  paddr_t      i_load_paddr [LOAD_PORTS];
  port_mask_t  o_conflict;
  entry_mask_t o_conflict_index_oh [LOAD_PORTS];
  port_mask_t  o_full;
  logic        o_req_valid;
  logic        i_req_ready;
  l2_cmd_t     o_req_cmd;
  paddr_t      o_req_addr;
  l2_tag_t     o_req_tag;
  logic        i_resp_valid;
  l2_tag_t     i_resp_tag;
  line_data_t  i_resp_data;
  logic        o_l1d_wr_valid;
  paddr_t      o_l1d_wr_paddr;
  byte_en_t    o_l1d_wr_be;
  line_data_t  o_l1d_wr_data;
  logic        o_resolve_valid;
  entry_mask_t o_resolve_index_oh;
  int          errors;
  int          checks;
  logic        model_idle;

  // Stimulus table
  port_mask_t  t_load  [ROWS];
  paddr_t      t_addr0 [ROWS];
  paddr_t      t_addr1 [ROWS];
  logic        t_ready [ROWS];
  int          n_rows;

  int          seed;
  int          pend_tag  [$];
  int          pend_wait [$];
  int          cycle;
  logic        foreign_sent;

  load_requester uut (.*);

  lrq_checker u_checker (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_load (i_load), .i_load_paddr (i_load_paddr),
    .i_conflict (o_conflict), .i_conflict_index_oh (o_conflict_index_oh), .i_full (o_full),
    .i_req_valid (o_req_valid), .i_req_ready (i_req_ready), .i_req_cmd (o_req_cmd),
    .i_req_addr (o_req_addr), .i_req_tag (o_req_tag), .i_resp_valid (i_resp_valid),
    .i_resp_tag (i_resp_tag), .i_resp_data (i_resp_data), .i_l1d_wr_valid (o_l1d_wr_valid),
    .i_l1d_wr_paddr (o_l1d_wr_paddr), .i_l1d_wr_be (o_l1d_wr_be),
    .i_l1d_wr_data (o_l1d_wr_data), .i_resolve_valid (o_resolve_valid),
    .i_resolve_index_oh (o_resolve_index_oh), .o_errors (errors), .o_checks (checks),
    .o_idle (model_idle)
  );

  task automatic add_row(input port_mask_t ld, input paddr_t a0, input paddr_t a1,
                         input logic rdy);
    t_load[n_rows]  = ld;
    t_addr0[n_rows] = a0;
    t_addr1[n_rows] = a1;
    t_ready[n_rows] = rdy;
    n_rows++;
  endtask

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // Memory-side responder with a random delay per read
  // ----------------------------------------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_req_valid && i_req_ready) begin
      pend_tag.push_back(int'(o_req_tag));
      pend_wait.push_back(1 + ({$random(seed)} % MAX_DELAY));
    end
  end

  always @(posedge i_clk) begin : respond
    int hit;

    #1;
    i_resp_valid = 1'b0;
    cycle++;
    for (int k = 0; k < pend_wait.size(); k++) begin
      pend_wait[k] = pend_wait[k] - 1;
    end
    hit = -1;
    for (int k = 0; k < pend_wait.size(); k++) begin
      if (hit < 0 && pend_wait[k] <= 0) begin
        hit = k;
      end
    end
    if (i_reset_n && cycle >= FOREIGN_CYC && !foreign_sent) begin
      // Upper bits of another source that the queue must ignore
      foreign_sent = 1'b1;
      i_resp_valid = 1'b1;
      i_resp_tag   = {2'b01, 2'b00};
      i_resp_data  = {8{16'hDEAD}};
    end else if (hit >= 0) begin
      i_resp_valid = 1'b1;
      i_resp_tag   = l2_tag_t'(pend_tag[hit]);
      i_resp_data  = {8{l2_tag_t'(pend_tag[hit]), 12'h5A3}};
      pend_tag.delete(hit);
      pend_wait.delete(hit);
    end
  end

  // Watchdog
  initial begin
    #((ROWS + 40) * 100);
    $display("Run timed out, the queue never drained");
    $display("Finished with errors");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    seed         = SEED;
    cycle        = 0;
    foreign_sent = 1'b0;
    n_rows       = 0;
    i_reset_n    = 1'b0;
    i_load       = '0;
    i_load_paddr = '{default: '0};
    i_req_ready  = 1'b0;
    i_resp_valid = 1'b0;
    i_resp_tag   = '0;
    i_resp_data  = '0;

    add_row(2'b11, 32'h1000, 32'h2000, 1'b0);
    add_row(2'b01, 32'h1008, 32'h0000, 1'b0);
    add_row(2'b11, 32'h3000, 32'h3004, 1'b1);
    add_row(2'b11, 32'h4000, 32'h5000, 1'b1);
    add_row(2'b11, 32'h6000, 32'h7000, 1'b0);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);
    add_row(2'b10, 32'h0000, 32'h2000, 1'b1);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);
    add_row(2'b11, 32'h8000, 32'h8040, 1'b1);
    add_row(2'b01, 32'h8004, 32'h0000, 1'b0);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);
    add_row(2'b11, 32'h1000, 32'h1010, 1'b0);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);
    add_row(2'b10, 32'h0000, 32'h5000, 1'b1);
    add_row(2'b11, 32'hB000, 32'hB000, 1'b1);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);
    add_row(2'b11, 32'hC000, 32'hD000, 1'b1);
    add_row(2'b00, 32'h0000, 32'h0000, 1'b1);

    repeat (5) @(posedge i_clk);
    #1 i_reset_n = 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      @(posedge i_clk);
      #1;
      i_load          = t_load[r];
      i_load_paddr[0] = t_addr0[r];
      i_load_paddr[1] = t_addr1[r];
      i_req_ready     = t_ready[r];
    end

    // Drain until every entry is freed in order
    @(posedge i_clk);
    #1;
    i_load      = '0;
    i_req_ready = 1'b1;
    while (!(model_idle && foreign_sent && pre_check_done())) begin
      @(posedge i_clk);
    end

    // Queue empty again, four fresh lines fill it and a fifth finds it full
    @(posedge i_clk);
    #1;
    i_load          = 2'b11;
    i_load_paddr[0] = 32'hE000;
    i_load_paddr[1] = 32'hF000;
    @(posedge i_clk);
    #1;
    i_load_paddr[0] = 32'h9000;
    i_load_paddr[1] = 32'hA000;
    @(posedge i_clk);
    #1;
    i_load          = 2'b01;
    i_load_paddr[0] = 32'h6000;
    @(posedge i_clk);
    #1 i_load = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    #1;

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // No read left waiting for its response
  function automatic bit pre_check_done();
    return pend_tag.size() == 0;
  endfunction

endmodule

`default_nettype wire

// File: tb.f
verilog/lrq_cfg_pkg.sv
verilog/lrq_types_pkg.sv
verilog/lrq_entry.sv
verilog/lrq_alloc.sv
verilog/lrq_issue.sv
verilog/lrq_refill.sv
verilog/load_requester.sv
sim/lrq_checker.sv
sim/tb_load_requester.sv

// File: verilog/load_requester.sv
`default_nettype none

module load_requester (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  // Load pipelines
  input  lrq_types_pkg::port_mask_t  i_load,
  input  lrq_types_pkg::paddr_t      i_load_paddr        [lrq_cfg_pkg::LOAD_PORTS],
  output lrq_types_pkg::port_mask_t  o_conflict,
  output lrq_types_pkg::entry_mask_t o_conflict_index_oh [lrq_cfg_pkg::LOAD_PORTS],
  output lrq_types_pkg::port_mask_t  o_full,
  // Line read request
  output logic                       o_req_valid,
  input  logic                       i_req_ready,
  output lrq_types_pkg::l2_cmd_t     o_req_cmd,
  output lrq_types_pkg::paddr_t      o_req_addr,
  output lrq_types_pkg::l2_tag_t     o_req_tag,
  // Line response
  input  logic                       i_resp_valid,
  input  lrq_types_pkg::l2_tag_t     i_resp_tag,
  input  lrq_types_pkg::line_data_t  i_resp_data,
  // L1D write
  output logic                       o_l1d_wr_valid,
  output lrq_types_pkg::paddr_t      o_l1d_wr_paddr,
  output lrq_types_pkg::byte_en_t    o_l1d_wr_be,
  output lrq_types_pkg::line_data_t  o_l1d_wr_data,
  // To the load queue
  output logic                       o_resolve_valid,
  output lrq_types_pkg::entry_mask_t o_resolve_index_oh
);

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  entry_state_t w_entry_state [ENTRIES];
  line_addr_t   w_entry_line  [ENTRIES];
  entry_mask_t  w_alloc_mask;
  line_addr_t   w_alloc_line  [ENTRIES];
  entry_mask_t  w_sent_mask;
  entry_mask_t  w_resolve_mask;
  entry_mask_t  w_free_mask;
  entry_mask_t  w_out_ptr_oh;

  // ----------------------------------------------------------------------
  // Entries
  // ----------------------------------------------------------------------
  for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
    lrq_entry u_entry (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_alloc      (w_alloc_mask[e]),
      .i_alloc_line (w_alloc_line[e]),
      .i_sent       (w_sent_mask[e]),
      .i_resolve    (w_resolve_mask[e]),
      .i_free       (w_free_mask[e]),
      .o_state      (w_entry_state[e]),
      .o_line       (w_entry_line[e])
    );
  end

  lrq_alloc u_alloc (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_load              (i_load),
    .i_load_paddr        (i_load_paddr),
    .i_entry_state       (w_entry_state),
    .i_entry_line        (w_entry_line),
    .o_conflict          (o_conflict),
    .o_conflict_index_oh (o_conflict_index_oh),
    .o_full              (o_full),
    .o_alloc_mask        (w_alloc_mask),
    .o_alloc_line        (w_alloc_line),
    .o_free_mask         (w_free_mask),
    .o_out_ptr_oh        (w_out_ptr_oh)
  );

  lrq_issue u_issue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_entry_state (w_entry_state),
    .i_entry_line  (w_entry_line),
    .i_out_ptr_oh  (w_out_ptr_oh),
    .i_req_ready   (i_req_ready),
    .o_req_valid   (o_req_valid),
    .o_req_cmd     (o_req_cmd),
    .o_req_addr    (o_req_addr),
    .o_req_tag     (o_req_tag),
    .o_sent_mask   (w_sent_mask)
  );

  lrq_refill u_refill (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_resp_valid       (i_resp_valid),
    .i_resp_tag         (i_resp_tag),
    .i_resp_data        (i_resp_data),
    .i_entry_state      (w_entry_state),
    .i_entry_line       (w_entry_line),
    .o_l1d_wr_valid     (o_l1d_wr_valid),
    .o_l1d_wr_paddr     (o_l1d_wr_paddr),
    .o_l1d_wr_be        (o_l1d_wr_be),
    .o_l1d_wr_data      (o_l1d_wr_data),
    .o_resolve_mask     (w_resolve_mask),
    .o_resolve_valid    (o_resolve_valid),
    .o_resolve_index_oh (o_resolve_index_oh)
  );

endmodule

`default_nettype wire

// File: verilog/lrq_alloc.sv
`default_nettype none

module lrq_alloc (
  input  wire                         i_clk,
  input  wire                         i_reset_n,
  input  lrq_types_pkg::port_mask_t   i_load,
  input  lrq_types_pkg::paddr_t       i_load_paddr        [lrq_cfg_pkg::LOAD_PORTS],
  input  lrq_types_pkg::entry_state_t i_entry_state       [lrq_cfg_pkg::ENTRIES],
  input  lrq_types_pkg::line_addr_t   i_entry_line        [lrq_cfg_pkg::ENTRIES],
  output lrq_types_pkg::port_mask_t   o_conflict,
  output lrq_types_pkg::entry_mask_t  o_conflict_index_oh [lrq_cfg_pkg::LOAD_PORTS],
  output lrq_types_pkg::port_mask_t   o_full,
  output lrq_types_pkg::entry_mask_t  o_alloc_mask,
  output lrq_types_pkg::line_addr_t   o_alloc_line        [lrq_cfg_pkg::ENTRIES],
  output lrq_types_pkg::entry_mask_t  o_free_mask,
  output lrq_types_pkg::entry_mask_t  o_out_ptr_oh
);

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  line_addr_t       w_line      [LOAD_PORTS];
  port_mask_t       w_port_hit  [LOAD_PORTS];
  port_mask_t       w_no_conflict;
  port_mask_t       w_accept;
  logic [ENTRY_W:0] w_rank      [LOAD_PORTS];
  logic [ENTRY_W:0] w_nc_cnt;
  logic [ENTRY_W:0] w_accept_cnt;
  entry_idx_t       w_tgt_idx   [LOAD_PORTS];
  entry_idx_t       w_in_idx;
  entry_mask_t      w_resolved;
  logic             w_out_valid;

  logic [ENTRY_W:0] r_free_cnt;
  entry_mask_t      r_in_ptr_oh;
  entry_mask_t      r_out_ptr_oh;

  // ----------------------------------------------------------------------
  // Conflict check against entries and lower ports
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < LOAD_PORTS; p++) begin : g_port
    assign w_line[p] = i_load_paddr[p][PADDR_W-1:LINE_OFFSET_W];

    for (genvar e = 0; e < ENTRIES; e++) begin : g_ent
      assign o_conflict_index_oh[p][e] = i_load[p] && (i_entry_state[e] != ST_EMPTY) &&
                                         (i_entry_line[e] == w_line[p]);
    end

    for (genvar q = 0; q < LOAD_PORTS; q++) begin : g_peer
      if (q < p) begin : g_lower
        assign w_port_hit[p][q] = i_load[p] && i_load[q] && (w_line[q] == w_line[p]);
      end else begin : g_upper
        assign w_port_hit[p][q] = 1'b0;
      end
    end

    assign o_conflict[p]    = (|o_conflict_index_oh[p]) || (|w_port_hit[p]);
    assign w_no_conflict[p] = i_load[p] && !o_conflict[p];
    assign w_accept[p]      = w_no_conflict[p] && !o_full[p];

    a_conflict_oh : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      $onehot0(o_conflict_index_oh[p]))
      else $error("line held by more than one entry, port %0d", p);
  end

  // Rank of each clean load and the full flags
  always_comb begin
    w_nc_cnt = '0;
    for (int p = 0; p < LOAD_PORTS; p++) begin
      w_rank[p] = w_nc_cnt;
      o_full[p] = w_no_conflict[p] && (w_nc_cnt >= r_free_cnt);
      if (w_no_conflict[p]) begin
        w_nc_cnt = w_nc_cnt + 1'b1;
      end
    end
  end

  assign w_accept_cnt = (w_nc_cnt > r_free_cnt) ? r_free_cnt : w_nc_cnt;

  // ----------------------------------------------------------------------
  // Allocation at the in-pointer, in port order
  // ----------------------------------------------------------------------
  always_comb begin
    w_in_idx = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (r_in_ptr_oh[e]) begin
        w_in_idx = entry_idx_t'(e);
      end
    end
  end

  always_comb begin
    o_alloc_mask = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      o_alloc_line[e] = w_line[0];
    end
    for (int p = 0; p < LOAD_PORTS; p++) begin
      w_tgt_idx[p] = w_in_idx + w_rank[p][ENTRY_W-1:0];
      if (w_accept[p]) begin
        o_alloc_mask[w_tgt_idx[p]] = 1'b1;
        o_alloc_line[w_tgt_idx[p]] = w_line[p];
      end
    end
  end

  // Head entry leaves once resolved
  for (genvar e = 0; e < ENTRIES; e++) begin : g_res
    assign w_resolved[e] = (i_entry_state[e] == ST_RESOLVED);
  end

  assign o_free_mask  = r_out_ptr_oh & w_resolved;
  assign w_out_valid  = |o_free_mask;
  assign o_out_ptr_oh = r_out_ptr_oh;

  // ----------------------------------------------------------------------
  // Pointers and free count
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh  <= entry_mask_t'(1);
      r_out_ptr_oh <= entry_mask_t'(1);
      r_free_cnt   <= (ENTRY_W + 1)'(ENTRIES);
    end else begin
      r_in_ptr_oh <= entry_mask_t'(1) << entry_idx_t'(w_in_idx + w_accept_cnt[ENTRY_W-1:0]);
      if (w_out_valid) begin
        r_out_ptr_oh <= {r_out_ptr_oh[ENTRIES-2:0], r_out_ptr_oh[ENTRIES-1]};
      end
      r_free_cnt <= r_free_cnt - w_accept_cnt + {{ENTRY_W{1'b0}}, w_out_valid};
    end
  end

  a_free_range : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_free_cnt <= (ENTRY_W + 1)'(ENTRIES))
    else $error("free count above queue size");

endmodule

`default_nettype wire

// File: verilog/lrq_cfg_pkg.sv
`default_nettype none

package lrq_cfg_pkg;

  // ----------------------------------------------------------------------
  // Queue geometry
  // ----------------------------------------------------------------------
  localparam int unsigned LOAD_PORTS = 2;
  localparam int unsigned ENTRIES    = 4;
  localparam int unsigned ENTRY_W    = $clog2(ENTRIES);

  // Address and line layout
  localparam int unsigned PADDR_W       = 32;
  localparam int unsigned LINE_BYTES    = 16;
  localparam int unsigned LINE_OFFSET_W = $clog2(LINE_BYTES);
  localparam int unsigned LINE_DATA_W   = LINE_BYTES * 8;

  // ----------------------------------------------------------------------
  // Next-level bus tag and command
  // ----------------------------------------------------------------------
  localparam int unsigned TAG_W = 4;

  // Upper two tag bits above the entry index
  localparam logic [1:0] TAG_SRC_RD_L1D = 2'b10;

  localparam logic [1:0] CMD_RD_LINE = 2'b01;

endpackage

`default_nettype wire

// File: verilog/lrq_entry.sv
`default_nettype none

module lrq_entry (
  input  wire                         i_clk,
  input  wire                         i_reset_n,
  input  logic                        i_alloc,
  input  lrq_types_pkg::line_addr_t   i_alloc_line,
  input  logic                        i_sent,
  input  logic                        i_resolve,
  input  logic                        i_free,
  output lrq_types_pkg::entry_state_t o_state,
  output lrq_types_pkg::line_addr_t   o_line
);

  import lrq_types_pkg::*;

  entry_state_t r_state;
  entry_state_t w_state_next;
  line_addr_t   r_line;

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      ST_EMPTY: begin
        if (i_alloc) begin
          w_state_next = ST_WAIT_SEND;
        end
      end
      ST_WAIT_SEND: begin
        if (i_sent) begin
          w_state_next = ST_WAIT_RESP;
        end
      end
      ST_WAIT_RESP: begin
        if (i_resolve) begin
          w_state_next = ST_RESOLVED;
        end
      end
      ST_RESOLVED: begin
        // Freed by the allocator only at the head of the queue
        if (i_free) begin
          w_state_next = ST_EMPTY;
        end
      end
      default: w_state_next = ST_EMPTY;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_EMPTY;
    end else begin
      r_state <= w_state_next;
    end
  end

  // Line address captured once per miss
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      r_line <= i_alloc_line;
    end
  end

  assign o_state = r_state;
  assign o_line  = r_line;

  // Allocator must only pick free entries
  a_alloc_empty : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> (r_state == ST_EMPTY))
    else $error("allocation hit a busy entry");

  // Refill may only resolve an outstanding read
  a_resolve_wait : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_resolve |-> (r_state == ST_WAIT_RESP))
    else $error("resolve outside WAIT_RESP");

endmodule

`default_nettype wire

// File: verilog/lrq_issue.sv
`default_nettype none

module lrq_issue (
  input  wire                         i_clk,
  input  wire                         i_reset_n,
  input  lrq_types_pkg::entry_state_t i_entry_state [lrq_cfg_pkg::ENTRIES],
  input  lrq_types_pkg::line_addr_t   i_entry_line  [lrq_cfg_pkg::ENTRIES],
  input  lrq_types_pkg::entry_mask_t  i_out_ptr_oh,
  input  logic                        i_req_ready,
  output logic                        o_req_valid,
  output lrq_types_pkg::l2_cmd_t      o_req_cmd,
  output lrq_types_pkg::paddr_t       o_req_addr,
  output lrq_types_pkg::l2_tag_t      o_req_tag,
  output lrq_types_pkg::entry_mask_t  o_sent_mask
);

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  entry_idx_t w_out_idx;
  entry_idx_t w_pos;
  entry_idx_t w_pick_idx;
  logic       w_found;

  // Oldest unsent entry found by scanning round from the out-pointer
  always_comb begin
    w_out_idx = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (i_out_ptr_oh[e]) begin
        w_out_idx = entry_idx_t'(e);
      end
    end
    w_found    = 1'b0;
    w_pick_idx = '0;
    for (int k = 0; k < ENTRIES; k++) begin
      w_pos = w_out_idx + entry_idx_t'(k);
      if (!w_found && (i_entry_state[w_pos] == ST_WAIT_SEND)) begin
        w_found    = 1'b1;
        w_pick_idx = w_pos;
      end
    end
  end

  assign o_req_valid = w_found;
  assign o_req_cmd   = CMD_RD_LINE;
  assign o_req_addr  = {i_entry_line[w_pick_idx], {LINE_OFFSET_W{1'b0}}};
  assign o_req_tag   = {TAG_SRC_RD_L1D, w_pick_idx};
  assign o_sent_mask = (o_req_valid && i_req_ready) ? (entry_mask_t'(1) << w_pick_idx) : '0;

  // Request must not change under back-pressure
  a_req_stable : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_req_valid && !i_req_ready) |=> (o_req_valid && $stable(o_req_addr) && $stable(o_req_tag)))
    else $error("read request changed while stalled");

endmodule

`default_nettype wire

// File: verilog/lrq_refill.sv
`default_nettype none

module lrq_refill (
  input  wire                         i_clk,
  input  wire                         i_reset_n,
  input  logic                        i_resp_valid,
  input  lrq_types_pkg::l2_tag_t      i_resp_tag,
  input  lrq_types_pkg::line_data_t   i_resp_data,
  input  lrq_types_pkg::entry_state_t i_entry_state [lrq_cfg_pkg::ENTRIES],
  input  lrq_types_pkg::line_addr_t   i_entry_line  [lrq_cfg_pkg::ENTRIES],
  output logic                        o_l1d_wr_valid,
  output lrq_types_pkg::paddr_t       o_l1d_wr_paddr,
  output lrq_types_pkg::byte_en_t     o_l1d_wr_be,
  output lrq_types_pkg::line_data_t   o_l1d_wr_data,
  output lrq_types_pkg::entry_mask_t  o_resolve_mask,
  output logic                        o_resolve_valid,
  output lrq_types_pkg::entry_mask_t  o_resolve_index_oh
);

  import lrq_cfg_pkg::*;
  import lrq_types_pkg::*;

  logic        r_rp1_valid;
  entry_idx_t  r_rp1_idx;
  line_data_t  r_rp1_data;
  logic        r_rp2_valid;
  entry_mask_t r_rp2_index_oh;
  line_addr_t  r_rp2_line;
  line_data_t  r_rp2_data;
  logic        r_resolve_valid;
  entry_mask_t r_resolve_index_oh;

  // ----------------------------------------------------------------------
  // Stage one takes L1D reads only and stage two looks up the line
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rp1_valid        <= 1'b0;
      r_rp2_valid        <= 1'b0;
      r_rp2_index_oh     <= '0;
      r_resolve_valid    <= 1'b0;
      r_resolve_index_oh <= '0;
    end else begin
      r_rp1_valid        <= i_resp_valid && (i_resp_tag[TAG_W-1:ENTRY_W] == TAG_SRC_RD_L1D);
      r_rp2_valid        <= r_rp1_valid;
      r_rp2_index_oh     <= entry_mask_t'(1) << r_rp1_idx;
      r_resolve_valid    <= r_rp2_valid;
      r_resolve_index_oh <= o_resolve_mask;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rp1_idx  <= i_resp_tag[ENTRY_W-1:0];
    r_rp1_data <= i_resp_data;
    r_rp2_line <= i_entry_line[r_rp1_idx];
    r_rp2_data <= r_rp1_data;
  end

  // L1D fill of the whole line
  assign o_l1d_wr_valid = r_rp2_valid;
  assign o_l1d_wr_paddr = {r_rp2_line, {LINE_OFFSET_W{1'b0}}};
  assign o_l1d_wr_be    = '1;
  assign o_l1d_wr_data  = r_rp2_data;

  // Entry flips to RESOLVED together with the resolve pulse
  assign o_resolve_mask     = r_rp2_valid ? r_rp2_index_oh : '0;
  assign o_resolve_valid    = r_resolve_valid;
  assign o_resolve_index_oh = r_resolve_index_oh;

  // Response tag must name an entry whose read is outstanding
  a_resp_target : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_rp1_valid |-> (i_entry_state[r_rp1_idx] == ST_WAIT_RESP))
    else $error("response for entry %0d not waiting", r_rp1_idx);

endmodule

`default_nettype wire

// File: verilog/lrq_types_pkg.sv
`default_nettype none

package lrq_types_pkg;

  import lrq_cfg_pkg::*;

  // Addresses
  typedef logic [PADDR_W-1:0]               paddr_t;
  typedef logic [PADDR_W-LINE_OFFSET_W-1:0] line_addr_t;

  // Entry indexing and masks
  typedef logic [ENTRY_W-1:0]    entry_idx_t;
  typedef logic [ENTRIES-1:0]    entry_mask_t;
  typedef logic [LOAD_PORTS-1:0] port_mask_t;

  // Line payload
  typedef logic [LINE_DATA_W-1:0] line_data_t;
  typedef logic [LINE_BYTES-1:0]  byte_en_t;

  // Bus fields
  typedef logic [TAG_W-1:0] l2_tag_t;
  typedef logic [1:0]       l2_cmd_t;

  // Life of one miss entry
  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_WAIT_SEND,
    ST_WAIT_RESP,
    ST_RESOLVED
  } entry_state_t;

endpackage

`default_nettype wire
